// ==== files.f ====
design/mem_pkg.sv
design/video_pkg.sv
design/mem_test_counter.sv
design/mem_test_fsm.sv
design/fb_writer.sv
design/mem_arbiter.sv
design/display.sv
verif/display_props.sv
verif/display_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run into sim.log, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module display_tb -f files.f -o display_tb_sim \
	&& ./obj_dir/display_tb_sim > sim.log 2>&1
grep -q "^NO ERRORS$" sim.log && echo "NO ERRORS" || { echo "ERRORS FOUND"; exit 1; }

// ==== verif/display_tb.sv ====
`timescale 1ns/1ns

module display_tb import mem_pkg::*, video_pkg::*; ();

	localparam logic [MEM_AW - 1:0] TFT_BASE = 24'h001000;
	localparam int TFT_LS = 64;
	localparam int PPU_X = 4;
	localparam int PPU_Y = 2;
	localparam logic [MEM_AW - 1:0] TEST_BASE = 24'h008000;
	localparam int TEST_SIZE = 32;

	logic clkSYS, arst_n;
	mem_req_t mem_req;
	logic req, ack, valid;
	logic [MEM_DW - 1:0] mem;
	pixel_t video;
	logic test_start;
	logic fb_empty, fb_full, test_busy, test_done, test_fail;

	// Memory model
	logic [MEM_DW - 1:0] model_mem [logic [MEM_AW - 1:0]];
	logic stall, corrupt_en, busy;
	logic [MEM_AW - 1:0] corrupt_addr;
	logic [MEM_DW - 1:0] rd_data;
	int delay, rd_wait, errors;
	logic [31:0] rng_mem, rng_pix;

	// Frame buffer words still to be checked
	logic [MEM_AW - 1:0] exp_addr [$];
	logic [MEM_DW - 1:0] exp_data [$];

	display #(
		.TFT_BASE(TFT_BASE),
		.TFT_LS(TFT_LS),
		.PPU_X(PPU_X),
		.PPU_Y(PPU_Y),
		.TEST_BASE(TEST_BASE),
		.TEST_SIZE(TEST_SIZE)
	) dut_i (.*);

	initial begin
		clkSYS = 1'b0;
		forever #2 clkSYS = ~clkSYS;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Acks after 0 to 3 cycles, read data two cycles after the ack
	always @(negedge clkSYS) begin
		if (arst_n !== 1'b1) begin
			ack <= 1'b0;
			valid <= 1'b0;
			busy = 1'b0;
			rd_wait = 0;
		end else begin
			valid <= 1'b0;
			if (rd_wait != 0) begin
				rd_wait = rd_wait - 1;
				if (rd_wait == 0) begin
					valid <= 1'b1;
					mem <= rd_data;
				end
			end
			if (ack) begin
				ack <= 1'b0;
				busy = 1'b0;
			end else if (req && !stall) begin
				if (!busy) begin
					busy = 1'b1;
					rng_mem = xorshift(rng_mem);
					delay = int'(rng_mem[1:0]);
				end
				if (delay == 0) begin
					ack <= 1'b1;
					if (mem_req.op == op_write) begin
						model_mem[mem_req.addr] = mem_req.data;
					end else begin
						rd_data = '0;
						if (model_mem.exists(mem_req.addr))
							rd_data = model_mem[mem_req.addr];
						// Damage the word only on its way back
						if (corrupt_en && mem_req.addr == corrupt_addr)
							rd_data = rd_data ^ 16'h0001;
						rd_wait = 2;
					end
				end else begin
					delay = delay - 1;
				end
			end
		end
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (exp === got) else begin
			errors++;
			$display("Fail %s: expected %0h, got %0h", name, exp, got);
		end
	endtask

	task automatic check_word(input string name, input logic [MEM_AW - 1:0] a,
			input logic [MEM_DW - 1:0] exp);
		assert (model_mem.exists(a)) else begin
			errors++;
			$display("%s: nothing was written at address %h", name, a);
		end
		if (model_mem.exists(a))
			check(name, 32'(exp), 32'(model_mem[a]));
	endtask

	task automatic wait_fb_empty(input string name);
		int n;
		n = 0;
		while (!fb_empty && n < 500) begin
			@(negedge clkSYS);
			n++;
		end
		if (!fb_empty) begin
			errors++;
			$display("%s: write queue did not drain in time", name);
		end
	endtask

	task automatic wait_test_done(input string name);
		int n;
		n = 0;
		while (!test_done && n < 4000) begin
			@(negedge clkSYS);
			n++;
		end
		if (!test_done) begin
			errors++;
			$display("%s: memory test did not finish in time", name);
		end
	endtask

	task automatic set_video(input logic [23:0] rgb, input logic hb, input logic vb);
		@(negedge clkSYS);
		video <= '{rgb: rgb, hblank: hb, vblank: vb};
	endtask

	task automatic pulse_start();
		@(negedge clkSYS);
		test_start <= 1'b1;
		@(negedge clkSYS);
		test_start <= 1'b0;
	endtask

	task automatic push_expected(input int line, input int px, input logic [23:0] rgb);
		exp_addr.push_back(TFT_BASE + MEM_AW'((PPU_Y + line) * TFT_LS + PPU_X + px));
		exp_data.push_back({rgb[23:19], rgb[15:10], rgb[7:3]});
	endtask

	task automatic check_frame(input string name);
		int i;
		for (i = 0; i < exp_addr.size(); i++)
			check_word(name, exp_addr[i], exp_data[i]);
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic check_test_words(input string name);
		logic [MEM_AW - 1:0] a;
		int i;
		for (i = 0; i < TEST_SIZE; i++) begin
			a = TEST_BASE + MEM_AW'(i);
			check_word(name, a, ~a[MEM_DW - 1:0]);
		end
	endtask

	// Three lines of two pixels, blanking held until the queue drains
	task automatic send_frame(input string name);
		int l, p;
		set_video(24'h0, 1'b1, 1'b1);
		for (l = 0; l < 3; l++) begin
			for (p = 0; p < 2; p++) begin
				rng_pix = xorshift(rng_pix);
				set_video(rng_pix[23:0], 1'b0, 1'b0);
				push_expected(l, p, rng_pix[23:0]);
			end
			set_video(24'h0, 1'b1, 1'b0);
			wait_fb_empty(name);
		end
		set_video(24'h0, 1'b1, 1'b1);
	endtask

	task automatic reset_state();
		check("reset_state", 0, req);
		check("reset_state", 0, test_busy);
		check("reset_state", 0, test_done);
		check("reset_state", 0, test_fail);
		check("reset_state", 0, fb_full);
		check("reset_state", 1, fb_empty);
	endtask

	task automatic frame_write();
		model_mem.delete();
		send_frame("frame_write");
		check_frame("frame_write");
		check("frame_write", 1, fb_empty);
	endtask

	task automatic memory_test_pass();
		model_mem.delete();
		pulse_start();
		check("memory_test_pass", 1, test_busy);
		wait_test_done("memory_test_pass");
		check("memory_test_pass", 0, test_busy);
		check("memory_test_pass", 0, test_fail);
		check_test_words("memory_test_pass");
	endtask

	task automatic memory_test_fault();
		corrupt_addr = TEST_BASE + 24'd5;
		corrupt_en = 1'b1;
		pulse_start();
		wait_test_done("memory_test_fault");
		check("memory_test_fault", 1, test_fail);
		corrupt_en = 1'b0;
		pulse_start();
		check("memory_test_fault", 0, test_fail);
		wait_test_done("memory_test_fault");
		check("memory_test_fault", 0, test_fail);
	endtask

	task automatic shared_traffic();
		model_mem.delete();
		pulse_start();
		send_frame("shared_traffic");
		wait_test_done("shared_traffic");
		check_frame("shared_traffic");
		check_test_words("shared_traffic");
		check("shared_traffic", 0, test_fail);
	endtask

	// Queue fills on the second pixel, the third is dropped
	task automatic backpressure();
		logic [MEM_AW - 1:0] a;
		int k;
		model_mem.delete();
		stall <= 1'b1;
		set_video(24'h0, 1'b1, 1'b1);
		for (k = 0; k < 3; k++) begin
			rng_pix = xorshift(rng_pix);
			set_video(rng_pix[23:0], 1'b0, 1'b0);
			if (k < 2)
				push_expected(0, k, rng_pix[23:0]);
		end
		set_video(24'h0, 1'b1, 1'b0);
		check("backpressure", 1, fb_full);
		repeat (4) @(negedge clkSYS);
		stall <= 1'b0;
		wait_fb_empty("backpressure");
		check_frame("backpressure");
		a = TFT_BASE + MEM_AW'(PPU_Y * TFT_LS + PPU_X + 2);
		check("backpressure", 0, 32'(model_mem.exists(a)));
	endtask

	initial begin
		arst_n = 1'b0;
		ack = 1'b0;
		valid = 1'b0;
		mem = '0;
		test_start = 1'b0;
		video = '{rgb: 24'h0, hblank: 1'b1, vblank: 1'b1};
		stall = 1'b0;
		corrupt_en = 1'b0;
		corrupt_addr = '0;
		busy = 1'b0;
		delay = 0;
		rd_wait = 0;
		errors = 0;
		rng_mem = 32'd62;
		rng_pix = 32'd62;
		repeat (16) @(negedge clkSYS);
		arst_n <= 1'b1;
		@(negedge clkSYS);
		reset_state();
		frame_write();
		memory_test_pass();
		memory_test_fault();
		shared_traffic();
		backpressure();
		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verif/display_props.sv ====
`timescale 1ns/1ns

module display_props import mem_pkg::*; (
	input logic clkSYS,
	input logic arst_n,
	input logic req,
	input mem_req_t mem_req,
	input logic ack,
	input logic fb_ack,
	input logic test_ack,
	input test_state_t state,
	input logic test_fail
);

	// Request and payload held until the other side takes them
	req_held: assert property (@(posedge clkSYS) disable iff (!arst_n)
		req && !ack |=> req && $stable(mem_req))
		else $error("request dropped or changed before its ack");

	// Only one client owns the port at a time
	one_ack: assert property (@(posedge clkSYS) disable iff (!arst_n)
		!(fb_ack && test_ack))
		else $error("both client acks high in the same cycle");

	idle_clean: assert property (@(posedge clkSYS) disable iff (!arst_n)
		state == st_idle |-> !test_fail)
		else $error("test_fail set while the memory test is idle");

endmodule

bind mem_arbiter display_props arb_props_i (
	.clkSYS(clkSYS),
	.arst_n(arst_n),
	.req(req),
	.mem_req(mem_req),
	.ack(ack),
	.fb_ack(fb_ack),
	.test_ack(test_ack),
	.state(mem_pkg::st_idle),
	.test_fail(1'b0)
);

bind mem_test_fsm display_props fsm_props_i (
	.clkSYS(clkSYS),
	.arst_n(arst_n),
	.req(req),
	.mem_req(test_req_out),
	.ack(ack),
	.fb_ack(1'b0),
	.test_ack(ack),
	.state(state),
	.test_fail(test_fail)
);

// ==== design/display.sv ====
`timescale 1ns/1ns

module display import mem_pkg::*, video_pkg::*; #(
	parameter logic [MEM_AW - 1:0] TFT_BASE = 24'h000000,
	parameter int TFT_LS = 64,
	parameter int PPU_X = 0,
	parameter int PPU_Y = 0,
	parameter logic [MEM_AW - 1:0] TEST_BASE = 24'h008000,
	parameter int TEST_SIZE = 32
) (
	input logic clkSYS,
	input logic arst_n,

	// Memory port
	output mem_req_t mem_req,
	output logic req,
	input logic ack,
	input logic [MEM_DW - 1:0] mem,
	input logic valid,

	input pixel_t video,
	input logic test_start,

	// Status
	output logic fb_empty,
	output logic fb_full,
	output logic test_busy,
	output logic test_done,
	output logic test_fail
);

	mem_req_t fb_wr_req, test_wr_req;
	logic fb_req, fb_ack;
	logic test_req, test_ack;

	fb_writer #(
		.TFT_BASE(TFT_BASE),
		.TFT_LS(TFT_LS),
		.PPU_X(PPU_X),
		.PPU_Y(PPU_Y)
	) fb_i (
		.clkSYS(clkSYS),
		.arst_n(arst_n),
		.video(video),
		.wr_req(fb_wr_req),
		.req(fb_req),
		.ack(fb_ack),
		.fb_empty(fb_empty),
		.fb_full(fb_full)
	);

	// Read data bypasses the arbiter, only the test reads
	mem_test_fsm #(
		.TEST_BASE(TEST_BASE),
		.TEST_SIZE(TEST_SIZE)
	) test_i (
		.clkSYS(clkSYS),
		.arst_n(arst_n),
		.test_start(test_start),
		.test_req_out(test_wr_req),
		.req(test_req),
		.ack(test_ack),
		.mem(mem),
		.valid(valid),
		.test_busy(test_busy),
		.test_done(test_done),
		.test_fail(test_fail)
	);

	mem_arbiter arb_i (
		.clkSYS(clkSYS),
		.arst_n(arst_n),
		.fb_req_in(fb_wr_req),
		.fb_req(fb_req),
		.fb_ack(fb_ack),
		.test_req_in(test_wr_req),
		.test_req(test_req),
		.test_ack(test_ack),
		.mem_req(mem_req),
		.req(req),
		.ack(ack)
	);

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter import mem_pkg::*; (
	input logic clkSYS,
	input logic arst_n,

	// Frame buffer writer client
	input mem_req_t fb_req_in,
	input logic fb_req,
	output logic fb_ack,

	// Memory test client
	input mem_req_t test_req_in,
	input logic test_req,
	output logic test_ack,

	// Memory port
	output mem_req_t mem_req,
	output logic req,
	input logic ack
);

	typedef enum logic [1:0] {
		gnt_none,
		gnt_fb,
		gnt_test
	} grant_t;

	grant_t grant;
	logic last_test;
	logic fb_ok, test_ok;
	logic idle, pick_test;

	// Ack goes straight back to the owner of the grant
	assign fb_ack = ack && (grant == gnt_fb);
	assign test_ack = ack && (grant == gnt_test);

	// The acked client still holds its req in the ack cycle, so skip it
	assign fb_ok = fb_req && !fb_ack;
	assign test_ok = test_req && !test_ack;

	// Free to grant when nothing is owned or the owner is being released
	assign idle = (grant == gnt_none) || ack;

	// On a tie serve whoever was not served last
	assign pick_test = test_ok && (!fb_ok || !last_test);

	assign req = (grant != gnt_none);

	always_ff @(posedge clkSYS or negedge arst_n) begin
		if (!arst_n) begin
			grant <= gnt_none;
			last_test <= 1'b0;
		end else if (idle) begin
			if (pick_test) begin
				grant <= gnt_test;
				last_test <= 1'b1;
			end else if (fb_ok) begin
				grant <= gnt_fb;
				last_test <= 1'b0;
			end else begin
				grant <= gnt_none;
			end
		end
	end

	// Request payload, held while a grant is open
	always_ff @(posedge clkSYS) begin
		if (idle)
			mem_req <= pick_test ? test_req_in : fb_req_in;
	end

endmodule

// ==== design/fb_writer.sv ====
`timescale 1ns/1ns

module fb_writer import mem_pkg::*, video_pkg::*; #(
	parameter logic [MEM_AW - 1:0] TFT_BASE = 24'h000000,
	parameter int TFT_LS = 64,
	parameter int PPU_X = 0,
	parameter int PPU_Y = 0
) (
	input logic clkSYS,
	input logic arst_n,

	input pixel_t video,

	output mem_req_t wr_req,
	output logic req,
	input logic ack,

	output logic fb_empty,
	output logic fb_full
);

	logic [MEM_AW - 1:0] x, y;
	logic [MEM_AW - 1:0] pix_addr;
	logic active;
	rgb565_t pix;
	mem_req_t new_req;

	mem_req_t queue [2];
	logic wr_ptr, rd_ptr;
	logic [1:0] count;
	logic push, pop;

	assign active = !video.hblank && !video.vblank;

	// Keep the top bits of each channel
	assign pix.r = video.rgb[R_MSB -: R_W];
	assign pix.g = video.rgb[G_MSB -: G_W];
	assign pix.b = video.rgb[B_MSB -: B_W];

	assign pix_addr = TFT_BASE + (MEM_AW'(PPU_Y) + y) * MEM_AW'(TFT_LS)
		+ MEM_AW'(PPU_X) + x;

	assign new_req.addr = pix_addr;
	assign new_req.data = pix;
	assign new_req.op = op_write;

	// Position tracking, x nonzero means a line is in progress
	always_ff @(posedge clkSYS or negedge arst_n) begin
		if (!arst_n) begin
			x <= '0;
			y <= '0;
		end else begin
			if (active)
				x <= x + 1'b1;
			else
				x <= '0;
			if (video.vblank)
				y <= '0;
			else if (!active && x != '0)
				y <= y + 1'b1;
		end
	end

	// Two-entry write queue, pixels arriving while full are lost
	assign fb_empty = (count == 2'd0);
	assign fb_full = (count == 2'd2);
	assign push = active && !fb_full;
	assign pop = ack;
	assign req = !fb_empty;
	assign wr_req = queue[rd_ptr];

	always_ff @(posedge clkSYS or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= !wr_ptr;
			if (pop)
				rd_ptr <= !rd_ptr;
			case ({push, pop})
				2'b10: count <= count + 2'd1;
				2'b01: count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clkSYS) begin
		if (push)
			queue[wr_ptr] <= new_req;
	end

endmodule

// ==== design/mem_test_fsm.sv ====
`timescale 1ns/1ns

module mem_test_fsm import mem_pkg::*; #(
	parameter logic [MEM_AW - 1:0] TEST_BASE = 24'h000000,
	parameter int TEST_SIZE = 16
) (
	input logic clkSYS,
	input logic arst_n,
	input logic test_start,

	output mem_req_t test_req_out,
	output logic req,
	input logic ack,
	input logic [MEM_DW - 1:0] mem,
	input logic valid,

	output logic test_busy,
	output logic test_done,
	output logic test_fail
);

	test_state_t state, state_next;
	logic [MEM_AW - 1:0] index;
	logic [MEM_AW - 1:0] addr;
	logic [MEM_DW - 1:0] pattern;
	logic last, clear, step, start;

	mem_test_counter #(.TEST_SIZE(TEST_SIZE)) cnt_i (
		.clkSYS(clkSYS),
		.arst_n(arst_n),
		.clear(clear),
		.step(step),
		.index(index),
		.last(last)
	);

	// Inverted address as the data pattern
	assign addr = TEST_BASE + index;
	assign pattern = ~addr[MEM_DW - 1:0];

	assign test_req_out.addr = addr;
	assign test_req_out.data = pattern;
	assign test_req_out.op = (state == st_write) ? op_write : op_read;
	assign req = (state == st_write) || (state == st_read_req);

	// Start is ignored while a pass is running
	assign start = test_start && (state == st_idle || state == st_done);
	assign clear = start || (state == st_write && ack && last);
	assign step = (state == st_write && ack && !last)
		|| (state == st_read_wait && valid && !last);

	assign test_busy = (state == st_write) || (state == st_read_req)
		|| (state == st_read_wait);
	assign test_done = (state == st_done);

	always_comb begin
		state_next = state;
		case (state)
			st_idle, st_done:
				if (test_start)
					state_next = st_write;
			st_write:
				if (ack && last)
					state_next = st_read_req;
			st_read_req:
				if (ack)
					state_next = st_read_wait;
			st_read_wait:
				if (valid)
					state_next = last ? st_done : st_read_req;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clkSYS or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			test_fail <= 1'b0;
		end else begin
			state <= state_next;
			// Sticky until the next accepted start
			if (start)
				test_fail <= 1'b0;
			else if (state == st_read_wait && valid && mem != pattern)
				test_fail <= 1'b1;
		end
	end

endmodule

// ==== design/mem_test_counter.sv ====
`timescale 1ns/1ns

module mem_test_counter import mem_pkg::*; #(
	parameter int TEST_SIZE = 16
) (
	input logic clkSYS,
	input logic arst_n,
	input logic clear,
	input logic step,
	output logic [MEM_AW - 1:0] index,
	output logic last
);

	// Flags the final word of the region
	assign last = (index == MEM_AW'(TEST_SIZE - 1));

	always_ff @(posedge clkSYS or negedge arst_n) begin
		if (!arst_n)
			index <= '0;
		else if (clear)
			index <= '0;
		else if (step)
			index <= index + 1'b1;
	end

endmodule

// ==== design/video_pkg.sv ====
package video_pkg;

	// Channel widths and positions for 24-bit to RGB565 packing
	localparam int R_W = 5;
	localparam int G_W = 6;
	localparam int B_W = 5;
	localparam int R_MSB = 23;
	localparam int G_MSB = 15;
	localparam int B_MSB = 7;

	// One video input sample
	typedef struct packed {
		logic [23:0] rgb;
		logic hblank;
		logic vblank;
	} pixel_t;

	typedef struct packed {
		logic [R_W - 1:0] r;
		logic [G_W - 1:0] g;
		logic [B_W - 1:0] b;
	} rgb565_t;

endpackage

// ==== design/mem_pkg.sv ====
package mem_pkg;

	// External memory port geometry
	localparam int MEM_AW = 24;
	localparam int MEM_DW = 16;

	typedef enum logic {
		op_read,
		op_write
	} mem_op_t;

	// One request as a client presents it, 41 bits
	typedef struct packed {
		logic [MEM_AW - 1:0] addr;
		logic [MEM_DW - 1:0] data;
		mem_op_t op;
	} mem_req_t;

	// Memory self-test sequence
	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_read_req,
		st_read_wait,
		st_done
	} test_state_t;

endpackage
